//--- logic/seq_pkg.sv
// Sizes, types and encodings shared by the vector sequencer
// Unit queue depths and the op to unit decode
package seq_pkg;

  //////////////////////////////
  // Instruction IDs
  //////////////////////////////

  // Instructions that may be in flight at once
  localparam int unsigned NrVInsn = 8;

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;

  // One bit per instruction ID
  typedef logic [NrVInsn-1:0] vinsn_mask_t;

  //////////////////////////////
  // Registers and units
  //////////////////////////////

  // Architectural vector registers
  localparam int unsigned NrVRegs = 32;

  typedef logic [$clog2(NrVRegs)-1:0] vreg_t;

  // ALU, multiply/FPU, load unit and store unit
  localparam int unsigned NrUnits = 4;

  typedef enum logic [1:0] {
    UNIT_ALU   = 2'd0,
    UNIT_MFPU  = 2'd1,
    UNIT_LOAD  = 2'd2,
    UNIT_STORE = 2'd3
  } unit_e;

  // Ops come in ranges, one range per unit
  typedef enum logic [3:0] {
    OP_VADD  = 4'd0,
    OP_VSUB  = 4'd1,
    OP_VAND  = 4'd2,
    OP_VOR   = 4'd3,
    OP_VXOR  = 4'd4,
    OP_VMUL  = 4'd5,
    OP_VMACC = 4'd6,
    OP_VFADD = 4'd7,
    OP_VFMUL = 4'd8,
    OP_VLE   = 4'd9,
    OP_VLSE  = 4'd10,
    OP_VSE   = 4'd11,
    OP_VSSE  = 4'd12
  } op_e;

  // Instruction queue depth of each unit
  localparam int unsigned AluQueueDepth   = 4;
  localparam int unsigned MfpuQueueDepth  = 4;
  localparam int unsigned LoadQueueDepth  = 2;
  localparam int unsigned StoreQueueDepth = 2;

  // Wide enough for the deepest queue
  localparam int unsigned QueueCntWidth = 3;

  // Unit that executes a given op
  function automatic unit_e unit_of_op(op_e op);
    unit_e unit;
    case (op) inside
      [OP_VMUL:OP_VFMUL]: unit = UNIT_MFPU;
      [OP_VLE:OP_VLSE]:   unit = UNIT_LOAD;
      [OP_VSE:OP_VSSE]:   unit = UNIT_STORE;
      // ALU range and unused codes
      default:            unit = UNIT_ALU;
    endcase
    return unit;
  endfunction

endpackage

//--- logic/vinsn_tracker.sv
// Running instruction bitmaps per functional unit
// Lowest free ID search, full and idle flags
`timescale 1ns/100ps

module vinsn_tracker (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // New instruction entering a unit
  input  logic                                         issue_i,
  input  seq_pkg::vid_t                                issue_id_i,
  input  seq_pkg::unit_e                               issue_unit_i,
  // Completion reports, one mask per unit
  input  seq_pkg::vinsn_mask_t [seq_pkg::NrUnits-1:0] unit_done_i,
  // Status
  output seq_pkg::vinsn_mask_t                         running_o,
  output seq_pkg::vid_t                                next_id_o,
  output logic                                         full_o,
  output logic                                         idle_o
);

  // A set bit marks an ID running on that unit
  seq_pkg::vinsn_mask_t [seq_pkg::NrUnits-1:0] unit_running_d, unit_running_q;

  always_comb begin
    unit_running_d = unit_running_q;
    for (int u = 0; u < seq_pkg::NrUnits; u++) begin
      // Retire finished IDs
      unit_running_d[u] = unit_running_q[u] & ~unit_done_i[u];
      // Mark the new ID on its target unit
      if (issue_i && (int'(issue_unit_i) == u)) begin
        unit_running_d[u][issue_id_i] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      unit_running_q <= '0;
    end else begin
      unit_running_q <= unit_running_d;
    end
  end

  // Merge the units into one bitmap
  always_comb begin
    running_o = '0;
    for (int u = 0; u < seq_pkg::NrUnits; u++) begin
      running_o |= unit_running_q[u];
    end
  end

  // Scan from the top so the lowest clear bit wins
  always_comb begin
    next_id_o = '0;
    for (int i = seq_pkg::NrVInsn - 1; i >= 0; i--) begin
      if (!running_o[i]) begin
        next_id_o = seq_pkg::vid_t'(i);
      end
    end
  end

  // No free ID left
  assign full_o = &running_o;
  // Nothing in flight
  assign idle_o = ~|running_o;

endmodule

//--- logic/vreg_access_list.sv
// Last reader and last writer of each vector register
// RAW, WAR and WAW hazard vectors for the incoming request
`timescale 1ns/100ps

module vreg_access_list (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Issue of the current request
  input  logic                 issue_i,
  input  seq_pkg::vid_t        issue_id_i,
  // Register operands of the current request
  input  seq_pkg::vreg_t       req_vd_i,
  input  logic                 req_use_vd_i,
  input  seq_pkg::vreg_t       req_vs1_i,
  input  logic                 req_use_vs1_i,
  input  seq_pkg::vreg_t       req_vs2_i,
  input  logic                 req_use_vs2_i,
  // IDs still in flight
  input  seq_pkg::vinsn_mask_t running_i,
  // Hazards against running instructions
  output seq_pkg::vinsn_mask_t hazard_vs1_o,
  output seq_pkg::vinsn_mask_t hazard_vs2_o,
  output seq_pkg::vinsn_mask_t hazard_vd_o
);

  // ID of the last writer and reader per register
  seq_pkg::vid_t wr_vid_q [seq_pkg::NrVRegs];
  seq_pkg::vid_t rd_vid_q [seq_pkg::NrVRegs];
  // Entry written and not yet cleared
  logic [seq_pkg::NrVRegs-1:0] wr_valid_q, rd_valid_q;
  // Entry whose ID is still running
  logic [seq_pkg::NrVRegs-1:0] wr_live, rd_live;

  always_comb begin
    for (int r = 0; r < seq_pkg::NrVRegs; r++) begin
      wr_live[r] = wr_valid_q[r] & running_i[wr_vid_q[r]];
      rd_live[r] = rd_valid_q[r] & running_i[rd_vid_q[r]];
    end
  end

  //////////////////////////////
  // Hazard lookup
  //////////////////////////////

  always_comb begin
    hazard_vs1_o = '0;
    hazard_vs2_o = '0;
    hazard_vd_o  = '0;
    // RAW on the source operands
    if (req_use_vs1_i && wr_live[req_vs1_i]) hazard_vs1_o[wr_vid_q[req_vs1_i]] = 1'b1;
    if (req_use_vs2_i && wr_live[req_vs2_i]) hazard_vs2_o[wr_vid_q[req_vs2_i]] = 1'b1;
    if (req_use_vd_i) begin
      // WAR shows up on both source vectors
      if (rd_live[req_vd_i]) begin
        hazard_vs1_o[rd_vid_q[req_vd_i]] = 1'b1;
        hazard_vs2_o[rd_vid_q[req_vd_i]] = 1'b1;
      end
      // WAW
      if (wr_live[req_vd_i]) hazard_vd_o[wr_vid_q[req_vd_i]] = 1'b1;
    end
  end

  //////////////////////////////
  // List update
  //////////////////////////////

  // Valid bits drop once their ID retires
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_valid_q <= '0;
      rd_valid_q <= '0;
    end else begin
      wr_valid_q <= wr_live;
      rd_valid_q <= rd_live;
      if (issue_i) begin
        if (req_use_vd_i) wr_valid_q[req_vd_i] <= 1'b1;
        if (req_use_vs1_i) rd_valid_q[req_vs1_i] <= 1'b1;
        if (req_use_vs2_i) rd_valid_q[req_vs2_i] <= 1'b1;
      end
    end
  end

  // Owner IDs of the entries
  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      if (req_use_vd_i) wr_vid_q[req_vd_i] <= issue_id_i;
      if (req_use_vs1_i) rd_vid_q[req_vs1_i] <= issue_id_i;
      if (req_use_vs2_i) rd_vid_q[req_vs2_i] <= issue_id_i;
    end
  end

endmodule

//--- logic/unit_queue_counter.sv
// Occupancy counter of one functional unit queue
`timescale 1ns/100ps

module unit_queue_counter #(
  // Instructions the unit can hold
  parameter int unsigned Depth = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  // Instruction entering the unit
  input  logic up_i,
  // Instruction leaving the unit
  input  logic down_i,
  output logic full_o
);

  logic [seq_pkg::QueueCntWidth-1:0] cnt_q;

  // Entry and exit on one edge cancel out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (up_i && !down_i) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (down_i && !up_i) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Requests never push past the depth
  assign full_o = (cnt_q == Depth[seq_pkg::QueueCntWidth-1:0]);

endmodule

//--- logic/issue_fsm.sv
// Accept decision and IDLE/WAIT state machine
// Registered issue strobe and address generation response
`timescale 1ns/100ps

module issue_fsm (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Dispatcher request
  input  logic                        req_valid_i,
  input  seq_pkg::op_e                req_op_i,
  input  seq_pkg::vreg_t              req_vd_i,
  input  seq_pkg::vreg_t              req_vs1_i,
  input  seq_pkg::vreg_t              req_vs2_i,
  input  logic                        req_use_vd_i,
  input  logic                        req_use_vs1_i,
  input  logic                        req_use_vs2_i,
  output logic                        req_ready_o,
  // Resource status
  input  seq_pkg::vid_t               next_id_i,
  input  logic                        ids_full_i,
  input  logic [seq_pkg::NrUnits-1:0] unit_full_i,
  // Hazards of the current request
  input  seq_pkg::vinsn_mask_t        hazard_vs1_i,
  input  seq_pkg::vinsn_mask_t        hazard_vs2_i,
  input  seq_pkg::vinsn_mask_t        hazard_vd_i,
  // Address generation
  input  logic                        addrgen_ack_i,
  input  logic                        addrgen_error_i,
  // Issue to the tracker, access list and counters
  output logic                        issue_o,
  output seq_pkg::unit_e              issue_unit_o,
  // Issue strobe towards the units
  output logic                        pe_req_valid_o,
  output seq_pkg::vid_t               pe_req_id_o,
  output seq_pkg::op_e                pe_req_op_o,
  output seq_pkg::unit_e              pe_req_unit_o,
  output seq_pkg::vreg_t              pe_req_vd_o,
  output seq_pkg::vreg_t              pe_req_vs1_o,
  output seq_pkg::vreg_t              pe_req_vs2_o,
  output seq_pkg::vinsn_mask_t        hazard_vs1_o,
  output seq_pkg::vinsn_mask_t        hazard_vs2_o,
  output seq_pkg::vinsn_mask_t        hazard_vd_o,
  // Dispatcher response
  output logic                        resp_valid_o,
  output logic                        resp_error_o
);

  // WAIT holds off requests until the address generation answers
  typedef enum logic {IDLE, WAIT} state_e;
  state_e state_d, state_q;

  seq_pkg::unit_e req_unit;
  logic           no_src;
  logic           any_hazard;
  logic           is_mem;

  //////////////////////////////
  // Accept decision
  //////////////////////////////

  assign req_unit     = seq_pkg::unit_of_op(req_op_i);
  assign issue_unit_o = req_unit;

  // Ops with no source operand only go when hazard free
  assign no_src     = !req_use_vs1_i && !req_use_vs2_i;
  assign any_hazard = |{hazard_vs1_i, hazard_vs2_i, hazard_vd_i};

  assign req_ready_o = (state_q == IDLE) && !ids_full_i && !unit_full_i[req_unit] &&
                       !(no_src && any_hazard);
  assign issue_o     = req_valid_i && req_ready_o;

  // Loads and stores wait for the address acknowledge
  assign is_mem = (req_unit == seq_pkg::UNIT_LOAD) || (req_unit == seq_pkg::UNIT_STORE);

  //////////////////////////////
  // State machine
  //////////////////////////////

  always_comb begin
    state_d      = state_q;
    resp_valid_o = 1'b0;
    resp_error_o = 1'b0;
    case (state_q)
      IDLE: begin
        if (issue_o && is_mem) state_d = WAIT;
      end
      WAIT: begin
        // Answer in the acknowledge cycle
        if (addrgen_ack_i) begin
          state_d      = IDLE;
          resp_valid_o = 1'b1;
          resp_error_o = addrgen_error_i;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= IDLE;
      pe_req_valid_o <= 1'b0;
    end else begin
      state_q        <= state_d;
      // Single cycle strobe
      pe_req_valid_o <= issue_o;
    end
  end

  // Issue payload, qualified by pe_req_valid_o
  always_ff @(posedge clk_i) begin
    if (issue_o) begin
      pe_req_id_o   <= next_id_i;
      pe_req_op_o   <= req_op_i;
      pe_req_unit_o <= req_unit;
      pe_req_vd_o   <= req_vd_i;
      pe_req_vs1_o  <= req_vs1_i;
      pe_req_vs2_o  <= req_vs2_i;
      hazard_vs1_o  <= hazard_vs1_i;
      hazard_vs2_o  <= hazard_vs2_i;
      hazard_vd_o   <= hazard_vd_i;
    end
  end

endmodule

//--- logic/vector_sequencer.sv
// Vector instruction sequencer top level
// Tracker, register access list, unit queue counters and issue FSM
`timescale 1ns/100ps

module vector_sequencer (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // Dispatcher request
  input  logic                                         req_valid_i,
  output logic                                         req_ready_o,
  input  seq_pkg::op_e                                 req_op_i,
  input  seq_pkg::vreg_t                               req_vd_i,
  input  logic                                         req_use_vd_i,
  input  seq_pkg::vreg_t                               req_vs1_i,
  input  logic                                         req_use_vs1_i,
  input  seq_pkg::vreg_t                               req_vs2_i,
  input  logic                                         req_use_vs2_i,
  // Issue strobe towards the units
  output logic                                         pe_req_valid_o,
  output seq_pkg::vid_t                                pe_req_id_o,
  output seq_pkg::op_e                                 pe_req_op_o,
  output seq_pkg::unit_e                               pe_req_unit_o,
  output seq_pkg::vreg_t                               pe_req_vd_o,
  output seq_pkg::vreg_t                               pe_req_vs1_o,
  output seq_pkg::vreg_t                               pe_req_vs2_o,
  output seq_pkg::vinsn_mask_t                         hazard_vs1_o,
  output seq_pkg::vinsn_mask_t                         hazard_vs2_o,
  output seq_pkg::vinsn_mask_t                         hazard_vd_o,
  // Completion per unit
  input  seq_pkg::vinsn_mask_t [seq_pkg::NrUnits-1:0] unit_done_i,
  // Address generation and response
  input  logic                                         addrgen_ack_i,
  input  logic                                         addrgen_error_i,
  output logic                                         resp_valid_o,
  output logic                                         resp_error_o,
  // Status
  output logic                                         idle_o,
  output seq_pkg::vinsn_mask_t                         running_o
);

  seq_pkg::vid_t               next_id;
  logic                        ids_full;
  logic                        issue;
  seq_pkg::unit_e              issue_unit;
  seq_pkg::vinsn_mask_t        req_hazard_vs1, req_hazard_vs2, req_hazard_vd;
  logic [seq_pkg::NrUnits-1:0] unit_full, unit_up, unit_down;

  vinsn_tracker tracker_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .issue_i     (issue),
    .issue_id_i  (next_id),
    .issue_unit_i(issue_unit),
    .unit_done_i (unit_done_i),
    .running_o   (running_o),
    .next_id_o   (next_id),
    .full_o      (ids_full),
    .idle_o      (idle_o)
  );

  vreg_access_list access_list_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_i      (issue),
    .issue_id_i   (next_id),
    .req_vd_i     (req_vd_i),
    .req_use_vd_i (req_use_vd_i),
    .req_vs1_i    (req_vs1_i),
    .req_use_vs1_i(req_use_vs1_i),
    .req_vs2_i    (req_vs2_i),
    .req_use_vs2_i(req_use_vs2_i),
    .running_i    (running_o),
    .hazard_vs1_o (req_hazard_vs1),
    .hazard_vs2_o (req_hazard_vs2),
    .hazard_vd_o  (req_hazard_vd)
  );

  //////////////////////////////
  // Unit queue counters
  //////////////////////////////

  // Count up on the target unit and down on any done of that unit
  always_comb begin
    for (int u = 0; u < seq_pkg::NrUnits; u++) begin
      unit_up[u]   = issue && (int'(issue_unit) == u);
      unit_down[u] = |unit_done_i[u];
    end
  end

  unit_queue_counter #(.Depth(seq_pkg::AluQueueDepth)) alu_cnt_inst (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .up_i  (unit_up[seq_pkg::UNIT_ALU]),
    .down_i(unit_down[seq_pkg::UNIT_ALU]),
    .full_o(unit_full[seq_pkg::UNIT_ALU])
  );

  unit_queue_counter #(.Depth(seq_pkg::MfpuQueueDepth)) mfpu_cnt_inst (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .up_i  (unit_up[seq_pkg::UNIT_MFPU]),
    .down_i(unit_down[seq_pkg::UNIT_MFPU]),
    .full_o(unit_full[seq_pkg::UNIT_MFPU])
  );

  unit_queue_counter #(.Depth(seq_pkg::LoadQueueDepth)) load_cnt_inst (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .up_i  (unit_up[seq_pkg::UNIT_LOAD]),
    .down_i(unit_down[seq_pkg::UNIT_LOAD]),
    .full_o(unit_full[seq_pkg::UNIT_LOAD])
  );

  unit_queue_counter #(.Depth(seq_pkg::StoreQueueDepth)) store_cnt_inst (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .up_i  (unit_up[seq_pkg::UNIT_STORE]),
    .down_i(unit_down[seq_pkg::UNIT_STORE]),
    .full_o(unit_full[seq_pkg::UNIT_STORE])
  );

  issue_fsm issue_fsm_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_op_i       (req_op_i),
    .req_vd_i       (req_vd_i),
    .req_vs1_i      (req_vs1_i),
    .req_vs2_i      (req_vs2_i),
    .req_use_vd_i   (req_use_vd_i),
    .req_use_vs1_i  (req_use_vs1_i),
    .req_use_vs2_i  (req_use_vs2_i),
    .req_ready_o    (req_ready_o),
    .next_id_i      (next_id),
    .ids_full_i     (ids_full),
    .unit_full_i    (unit_full),
    .hazard_vs1_i   (req_hazard_vs1),
    .hazard_vs2_i   (req_hazard_vs2),
    .hazard_vd_i    (req_hazard_vd),
    .addrgen_ack_i  (addrgen_ack_i),
    .addrgen_error_i(addrgen_error_i),
    .issue_o        (issue),
    .issue_unit_o   (issue_unit),
    .pe_req_valid_o (pe_req_valid_o),
    .pe_req_id_o    (pe_req_id_o),
    .pe_req_op_o    (pe_req_op_o),
    .pe_req_unit_o  (pe_req_unit_o),
    .pe_req_vd_o    (pe_req_vd_o),
    .pe_req_vs1_o   (pe_req_vs1_o),
    .pe_req_vs2_o   (pe_req_vs2_o),
    .hazard_vs1_o   (hazard_vs1_o),
    .hazard_vs2_o   (hazard_vs2_o),
    .hazard_vd_o    (hazard_vd_o),
    .resp_valid_o   (resp_valid_o),
    .resp_error_o   (resp_error_o)
  );

endmodule

//--- dv/tb_clock_gen.sv
// Testbench clock with a 100 ns period
// Active low reset held for two cycles
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int HalfPeriod = 50;

  initial begin
    clk_o = 1'b0;
    forever #HalfPeriod clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- dv/vector_sequencer_tb.sv
// Testbench top for the vector sequencer
// Replays the stimulus file one line per cycle and checks the outputs
`timescale 1ns/100ps

module vector_sequencer_tb;

  localparam int MaxLines     = 64;
  localparam int ResetTimeout = 20;
  // Whole run, in clock cycles
  localparam int CycleLimit   = 200;
  // Sample point after the falling edge, just before the rising edge
  localparam int CheckDelay   = 40;

  logic clk;
  logic rst_n;

  // DUT inputs
  logic                                        req_valid;
  seq_pkg::op_e                                req_op;
  seq_pkg::vreg_t                              req_vd, req_vs1, req_vs2;
  logic                                        use_vd, use_vs1, use_vs2;
  seq_pkg::vinsn_mask_t [seq_pkg::NrUnits-1:0] unit_done;
  logic                                        addrgen_ack, addrgen_error;

  // DUT outputs
  logic                 req_ready;
  logic                 pe_req_valid;
  seq_pkg::vid_t        pe_req_id;
  seq_pkg::op_e         pe_req_op;
  seq_pkg::unit_e       pe_req_unit;
  seq_pkg::vreg_t       pe_req_vd, pe_req_vs1, pe_req_vs2;
  seq_pkg::vinsn_mask_t hazard_vs1, hazard_vs2, hazard_vd;
  logic                 resp_valid, resp_error;
  logic                 idle;
  seq_pkg::vinsn_mask_t running;

  // One packed line per cycle, layout in the stimulus file header
  logic [119:0] stim [MaxLines];

  // Line of the cycle before, source of the issued payload
  logic [119:0]         prev_line;
  // IDs in flight according to the expected issues and the dones
  seq_pkg::vinsn_mask_t exp_running;

  int errors;
  int checks;
  int test_errors;
  int cur_test;
  int line_cnt;
  int wait_cnt;

  tb_clock_gen clk_gen_inst (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  vector_sequencer vector_sequencer_inst (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .req_valid_i    (req_valid),
    .req_ready_o    (req_ready),
    .req_op_i       (req_op),
    .req_vd_i       (req_vd),
    .req_use_vd_i   (use_vd),
    .req_vs1_i      (req_vs1),
    .req_use_vs1_i  (use_vs1),
    .req_vs2_i      (req_vs2),
    .req_use_vs2_i  (use_vs2),
    .pe_req_valid_o (pe_req_valid),
    .pe_req_id_o    (pe_req_id),
    .pe_req_op_o    (pe_req_op),
    .pe_req_unit_o  (pe_req_unit),
    .pe_req_vd_o    (pe_req_vd),
    .pe_req_vs1_o   (pe_req_vs1),
    .pe_req_vs2_o   (pe_req_vs2),
    .hazard_vs1_o   (hazard_vs1),
    .hazard_vs2_o   (hazard_vs2),
    .hazard_vd_o    (hazard_vd),
    .unit_done_i    (unit_done),
    .addrgen_ack_i  (addrgen_ack),
    .addrgen_error_i(addrgen_error),
    .resp_valid_o   (resp_valid),
    .resp_error_o   (resp_error),
    .idle_o         (idle),
    .running_o      (running)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic string test_name(input int t);
    case (t)
      1:       return "ID allocation and idle";
      2:       return "RAW, WAR and WAW hazards";
      3:       return "unit queue full";
      4:       return "load wait and response";
      5:       return "no-operand stall";
      6:       return "ID exhaustion";
      default: return "unknown";
    endcase
  endfunction

  // Unit that owns an op, by op range
  function automatic logic [1:0] expected_unit(input logic [3:0] op);
    if (op >= 4'd11 && op <= 4'd12) return 2'd3;
    if (op >= 4'd9 && op <= 4'd10) return 2'd2;
    if (op >= 4'd5 && op <= 4'd8) return 2'd1;
    return 2'd0;
  endfunction

  task automatic check_value(input string name, input logic [7:0] act, input logic [7:0] exp);
    checks++;
    assert (act === exp) else begin
      $display("ERROR t=%0t %s expected %0h actual %0h", $time, name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  // Apply the input columns of one line
  task automatic apply_inputs(input logic [119:0] v);
    req_valid     = v[112];
    req_op        = seq_pkg::op_e'(v[111:108]);
    use_vd        = v[106];
    use_vs1       = v[105];
    use_vs2       = v[104];
    req_vd        = v[100:96];
    req_vs1       = v[92:88];
    req_vs2       = v[84:80];
    // ALU, MFPU, load, store
    unit_done[0]  = v[79:72];
    unit_done[1]  = v[71:64];
    unit_done[2]  = v[63:56];
    unit_done[3]  = v[55:48];
    addrgen_ack   = v[45];
    addrgen_error = v[44];
  endtask

  // Compare against the expected columns of one line, p is the line before
  task automatic compare_outputs(input logic [119:0] v, input logic [119:0] p);
    // Dones of the line before retire, an issue adds its ID
    exp_running &= ~(p[79:72] | p[71:64] | p[63:56] | p[55:48]);
    if (v[36]) begin
      exp_running[v[34:32]] = 1'b1;
    end
    check_value("req_ready_o", 8'(req_ready), 8'(v[40]));
    check_value("pe_req_valid_o", 8'(pe_req_valid), 8'(v[36]));
    // Payload only matters with the strobe
    if (v[36]) begin
      check_value("pe_req_id_o", 8'(pe_req_id), 8'(v[34:32]));
      // Fields of the request accepted on the line before
      check_value("pe_req_op_o", 8'(pe_req_op), 8'(p[111:108]));
      check_value("pe_req_unit_o", 8'(pe_req_unit), 8'(expected_unit(p[111:108])));
      check_value("pe_req_vd_o", 8'(pe_req_vd), 8'(p[100:96]));
      check_value("pe_req_vs1_o", 8'(pe_req_vs1), 8'(p[92:88]));
      check_value("pe_req_vs2_o", 8'(pe_req_vs2), 8'(p[84:80]));
      check_value("hazard_vs1_o", hazard_vs1, v[31:24]);
      check_value("hazard_vs2_o", hazard_vs2, v[23:16]);
      check_value("hazard_vd_o", hazard_vd, v[15:8]);
    end
    check_value("resp_valid_o", 8'(resp_valid), 8'(v[5]));
    if (v[5]) begin
      check_value("resp_error_o", 8'(resp_error), 8'(v[4]));
    end
    check_value("idle_o", 8'(idle), 8'(v[0]));
    check_value("running_o", running, exp_running);
  endtask

  task automatic report_test(input int t);
    if (test_errors == 0) begin
      $display("test %0d (%s) passed", t, test_name(t));
    end else begin
      $display("test %0d (%s) failed with %0d mismatches", t, test_name(t), test_errors);
    end
    test_errors = 0;
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    errors      = 0;
    checks      = 0;
    test_errors = 0;
    cur_test    = 0;
    prev_line   = '0;
    exp_running = '0;
    apply_inputs('0);
    $readmemh("dv/vector_sequencer_stimulus.txt", stim);

    // Reset release
    wait_cnt = 0;
    while (rst_n !== 1'b1 && wait_cnt < ResetTimeout) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (rst_n !== 1'b1) begin
      $display("reset was never released within %0d cycles", ResetTimeout);
      $display("ERRORS FOUND");
      $finish;
    end

    // A line with test number zero ends the list
    line_cnt = 0;
    while (line_cnt < MaxLines && stim[line_cnt][119:116] != 4'h0) begin
      @(negedge clk);
      if (int'(stim[line_cnt][119:116]) != cur_test) begin
        if (cur_test != 0) report_test(cur_test);
        cur_test = int'(stim[line_cnt][119:116]);
      end
      apply_inputs(stim[line_cnt]);
      #CheckDelay;
      compare_outputs(stim[line_cnt], prev_line);
      prev_line = stim[line_cnt];
      line_cnt++;
    end
    if (cur_test != 0) report_test(cur_test);

    @(negedge clk);
    apply_inputs('0);
    $display("lines %0d, checks %0d, mismatches %0d", line_cnt, checks, errors);
    if (errors == 0 && line_cnt > 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog against a stalled run
  initial begin
    #(CycleLimit * 100);
    $display("timeout, the run did not end within %0d cycles", CycleLimit);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- vector_sequencer.f
logic/seq_pkg.sv
logic/vinsn_tracker.sv
logic/vreg_access_list.sv
logic/unit_queue_counter.sv
logic/issue_fsm.sv
logic/vector_sequencer.sv
dv/tb_clock_gen.sv
dv/vector_sequencer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the vector sequencer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f vector_sequencer.f \
  --top-module vector_sequencer_tb \
  -o vector_sequencer_sim

output=$(./obj_dir/vector_sequencer_sim)
echo "$output"

if echo "$output" | grep -q "NO ERRORS"; then
  exit 0
else
  exit 1
fi

//--- dv/vector_sequencer_stimulus.txt
// test_valid_op_use(vd,vs1,vs2)_vd_vs1_vs2_doneAlu_doneMfpu_doneLoad_doneStore_ackErr
//   _expReady_expPeValid_expId_expHzVs1_expHzVs2_expHzVd_expResp(valid,err)_expIdle
1_1_0_6_01_02_00_00_00_00_00_0_1_0_0_00_00_00_0_1
1_1_0_6_04_05_00_00_00_00_00_0_1_1_0_00_00_00_0_0
1_1_0_6_06_07_00_00_00_00_00_0_1_1_1_00_00_00_0_0
1_0_0_0_00_00_00_01_00_00_00_0_1_1_2_00_00_00_0_0
1_1_0_6_08_09_00_00_00_00_00_0_1_0_0_00_00_00_0_0
1_0_0_0_00_00_00_02_00_00_00_0_1_1_0_00_00_00_0_0
1_0_0_0_00_00_00_04_00_00_00_0_1_0_0_00_00_00_0_0
1_0_0_0_00_00_00_01_00_00_00_0_1_0_0_00_00_00_0_0
1_0_0_0_00_00_00_00_00_00_00_0_1_0_0_00_00_00_0_1
2_1_0_6_03_0a_00_00_00_00_00_0_1_0_0_00_00_00_0_1
2_1_0_6_0b_03_00_00_00_00_00_0_1_1_0_00_00_00_0_0
2_1_0_6_03_0c_00_00_00_00_00_0_1_1_1_01_00_00_0_0
2_0_0_0_00_00_00_01_00_00_00_0_1_1_2_02_02_01_0_0
2_0_0_0_00_00_00_02_00_00_00_0_1_0_0_00_00_00_0_0
2_0_0_0_00_00_00_04_00_00_00_0_1_0_0_00_00_00_0_0
2_1_0_6_0b_03_00_00_00_00_00_0_1_0_0_00_00_00_0_1
2_0_0_0_00_00_00_01_00_00_00_0_1_1_0_00_00_00_0_0
3_1_0_6_10_11_00_00_00_00_00_0_1_0_0_00_00_00_0_1
3_1_0_6_12_13_00_00_00_00_00_0_1_1_0_00_00_00_0_0
3_1_0_6_14_15_00_00_00_00_00_0_1_1_1_00_00_00_0_0
3_1_0_6_16_17_00_00_00_00_00_0_1_1_2_00_00_00_0_0
3_0_0_6_18_19_00_00_00_00_00_0_0_1_3_00_00_00_0_0
3_1_5_6_1a_1b_00_00_00_00_00_0_1_0_0_00_00_00_0_0
3_1_0_6_18_19_00_01_00_00_00_0_0_1_4_00_00_00_0_0
3_1_0_6_18_19_00_00_00_00_00_0_1_0_0_00_00_00_0_0
3_0_0_0_00_00_00_01_10_00_00_0_0_1_0_00_00_00_0_0
3_0_0_0_00_00_00_02_00_00_00_0_1_0_0_00_00_00_0_0
3_0_0_0_00_00_00_04_00_00_00_0_1_0_0_00_00_00_0_0
3_0_0_0_00_00_00_08_00_00_00_0_1_0_0_00_00_00_0_0
4_1_9_6_05_06_00_00_00_00_00_0_1_0_0_00_00_00_0_1
4_0_0_0_00_00_00_00_00_00_00_0_0_1_0_00_00_00_0_0
4_0_0_0_00_00_00_00_00_00_00_2_0_0_0_00_00_00_2_0
4_1_9_6_07_08_00_00_00_01_00_0_1_0_0_00_00_00_0_0
4_0_0_0_00_00_00_00_00_00_00_0_0_1_1_00_00_00_0_0
4_0_0_0_00_00_00_00_00_00_00_3_0_0_0_00_00_00_3_0
4_0_0_0_00_00_00_00_00_02_00_0_1_0_0_00_00_00_0_0
5_1_0_6_09_0a_00_00_00_00_00_0_1_0_0_00_00_00_0_1
5_1_0_4_09_00_00_00_00_00_00_0_0_1_0_00_00_00_0_0
5_1_0_4_09_00_00_01_00_00_00_0_0_0_0_00_00_00_0_0
5_1_0_4_09_00_00_00_00_00_00_0_1_0_0_00_00_00_0_1
5_0_0_0_00_00_00_01_00_00_00_0_1_1_0_00_00_00_0_0
6_1_0_6_14_15_00_00_00_00_00_0_1_0_0_00_00_00_0_1
6_1_0_6_16_17_00_00_00_00_00_0_1_1_0_00_00_00_0_0
6_1_0_6_18_19_00_00_00_00_00_0_1_1_1_00_00_00_0_0
6_1_0_6_1a_1b_00_00_00_00_00_0_1_1_2_00_00_00_0_0
6_1_5_6_1c_1d_00_00_00_00_00_0_1_1_3_00_00_00_0_0
6_1_5_6_1e_1f_00_00_00_00_00_0_1_1_4_00_00_00_0_0
6_1_5_6_00_01_00_00_00_00_00_0_1_1_5_00_00_00_0_0
6_1_5_6_02_03_00_00_00_00_00_0_1_1_6_00_00_00_0_0
6_1_9_6_04_05_00_00_00_00_00_0_0_1_7_00_00_00_0_0
6_1_9_6_04_05_00_00_10_00_00_0_0_0_0_00_00_00_0_0
6_1_9_6_04_05_00_00_00_00_00_0_1_0_0_00_00_00_0_0
6_0_0_0_00_00_00_00_00_00_00_2_0_1_4_00_00_00_2_0
// End of list
0_0_0_0_00_00_00_00_00_00_00_0_0_0_0_00_00_00_0_0
